//--- include/cpu_cfg.svh
// Core configuration: widths, cycle counts and reset values of the multicycle MIPS core
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data and address width
`define CPU_XLEN 32

// Register index width
`define CPU_REG_AW 5

// Fetch length, read strobe high for all but the last cycle
`define CPU_FETCH_CYCLES 4

// Multiplier iterations
`define CPU_MULT_STEPS 32

// Stack pointer set up right after reset
`define CPU_SP_INDEX 29
`define CPU_SP_INIT 227

// Opcode and function field width
`define CPU_OPCODE_W 6

`endif

//--- source/cpuPkg.sv
// Shared types and MIPS instruction encodings of the multicycle core
`include "cpu_cfg.svh"

package cpuPkg;

    typedef enum logic [2:0] {
        StReset, StFetch, StDecode, StAluOp, StShiftOp, StMultOp, StMoveHiLo, StException
    } ctrlState_t;

    typedef enum logic {AluAdd, AluSub} aluOp_t;

    typedef enum logic [2:0] {ShNone, ShLoad, ShSll, ShSrl, ShSra} shiftOp_t;

    typedef enum logic [2:0] {WbAluOut, WbShift, WbHi, WbLo, WbSpInit} wbSrc_t;

    typedef enum logic [1:0] {ExcNone, ExcOverflow, ExcBadOpcode} excCause_t;

    // Opcodes
    parameter logic [`CPU_OPCODE_W-1:0] OpTypeR = 6'b000000;
    parameter logic [`CPU_OPCODE_W-1:0] OpAddi = 6'b001000;

    // R-type function codes
    parameter logic [`CPU_OPCODE_W-1:0] FnAdd = 6'b100000;
    parameter logic [`CPU_OPCODE_W-1:0] FnSub = 6'b100010;
    parameter logic [`CPU_OPCODE_W-1:0] FnMult = 6'b011000;
    parameter logic [`CPU_OPCODE_W-1:0] FnMfhi = 6'b010000;
    parameter logic [`CPU_OPCODE_W-1:0] FnMflo = 6'b010010;
    parameter logic [`CPU_OPCODE_W-1:0] FnSll = 6'b000000;
    parameter logic [`CPU_OPCODE_W-1:0] FnSrl = 6'b000010;
    parameter logic [`CPU_OPCODE_W-1:0] FnSra = 6'b000011;
    parameter logic [`CPU_OPCODE_W-1:0] FnSllv = 6'b000100;
    parameter logic [`CPU_OPCODE_W-1:0] FnSrav = 6'b000111;

endpackage

//--- source/aluUnit.sv
// Adder and subtractor with signed overflow detection
`include "cpu_cfg.svh"

module aluUnit (
    input  logic [`CPU_XLEN-1:0]  a,
    input  logic [`CPU_XLEN-1:0]  b,
    input  cpuPkg::aluOp_t        op,
    output logic [`CPU_XLEN-1:0]  result,
    output logic                  overflow
);

    localparam int Msb = `CPU_XLEN - 1;

    logic [`CPU_XLEN-1:0] bOperand;
    logic sub;

    assign sub = op == cpuPkg::AluSub;

    // Subtract as a plus inverted b plus one
    assign bOperand = sub ? ~b : b;
    assign result = a + bOperand + `CPU_XLEN'(sub);

    // Equal operand signs but a result of the other sign
    assign overflow = (a[Msb] == bOperand[Msb]) && (result[Msb] != a[Msb]);

endmodule

//--- source/shiftUnit.sv
// Shift register: loads a word, then shifts it in place logically or arithmetically
`include "cpu_cfg.svh"

module shiftUnit (
    input  logic                           clk,
    input  logic                           rstN,
    input  cpuPkg::shiftOp_t               op,
    input  logic [`CPU_XLEN-1:0]           din,
    input  logic [$clog2(`CPU_XLEN)-1:0]   amount,
    output logic [`CPU_XLEN-1:0]           dout
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dout <= '0;
        end else begin
            case (op)
                cpuPkg::ShLoad: begin
                    dout <= din;
                end
                cpuPkg::ShSll: begin
                    dout <= dout << amount;
                end
                cpuPkg::ShSrl: begin
                    dout <= dout >> amount;
                end
                cpuPkg::ShSra: begin
                    dout <= $signed(dout) >>> amount;
                end
                default: begin
                    dout <= dout;
                end
            endcase
        end
    end

endmodule

//--- source/multUnit.sv
// Iterative signed shift-and-add multiplier producing Hi and Lo
`include "cpu_cfg.svh"

module multUnit (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  start,
    input  logic [`CPU_XLEN-1:0]  multiplicand,
    input  logic [`CPU_XLEN-1:0]  multiplier,
    output logic                  busy,
    output logic                  done,
    output logic [`CPU_XLEN-1:0]  hi,
    output logic [`CPU_XLEN-1:0]  lo
);

    localparam int CntW = $clog2(`CPU_MULT_STEPS);

    logic [CntW-1:0] count;
    logic [`CPU_XLEN-1:0] mcand;
    logic [`CPU_XLEN:0] acc, mcandExt, sum;
    logic last;

    assign last = count == CntW'(`CPU_MULT_STEPS - 1);
    assign done = busy && last;
    assign mcandExt = {mcand[`CPU_XLEN-1], mcand};
    assign hi = acc[`CPU_XLEN-1:0];

    // Multiplier MSB carries negative weight, so the last step subtracts
    always_comb begin
        if (!lo[0]) begin
            sum = acc;
        end else if (last) begin
            sum = acc - mcandExt;
        end else begin
            sum = acc + mcandExt;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy <= 1'b1;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
            busy <= !last;
        end
    end

    // Arithmetic right shift of the partial product each step
    always_ff @(posedge clk) begin
        if (start) begin
            mcand <= multiplicand;
            acc <= '0;
            lo <= multiplier;
        end else if (busy) begin
            {acc, lo} <= {sum[`CPU_XLEN], sum, lo[`CPU_XLEN-1:1]};
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) start |-> !busy)
        else $error("multiplier restarted while busy");

endmodule

//--- source/regFile.sv
// Register file with two combinational reads, one synchronous write and a zero register
`include "cpu_cfg.svh"

module regFile (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [`CPU_REG_AW-1:0]  rdAddrA,
    input  logic [`CPU_REG_AW-1:0]  rdAddrB,
    input  logic                    wrEn,
    input  logic [`CPU_REG_AW-1:0]  wrAddr,
    input  logic [`CPU_XLEN-1:0]    wrData,
    output logic [`CPU_XLEN-1:0]    rdDataA,
    output logic [`CPU_XLEN-1:0]    rdDataB
);

    localparam int NumRegs = 2 ** `CPU_REG_AW;

    logic [`CPU_XLEN-1:0] regs [NumRegs];

    // Entry 0 is cleared by reset and never written
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

    assert property (@(posedge clk) disable iff (!rstN) wrEn |-> !$isunknown(wrData))
        else $error("unknown write data to register %0d", wrAddr);

endmodule

//--- source/controlFsm.sv
// Control FSM sequencing fetch, decode and execute strobes of the datapath
`include "cpu_cfg.svh"

module controlFsm (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [`CPU_OPCODE_W-1:0]  opcode,
    input  logic [`CPU_OPCODE_W-1:0]  funct,
    input  logic                      overflow,
    input  logic                      multDone,
    output logic                      pcWrite,
    output logic                      irWrite,
    output logic                      instrRead,
    output logic                      abLoad,
    output logic                      aluOutLoad,
    output cpuPkg::aluOp_t            aluOp,
    output logic                      aluSrcB,
    output cpuPkg::shiftOp_t          shiftOp,
    output logic                      shiftVar,
    output logic                      multStart,
    output logic                      hiLoLoad,
    output logic                      regWrite,
    output cpuPkg::wbSrc_t            wbSrc,
    output logic                      wrSelRt,
    output logic                      excValid,
    output cpuPkg::excCause_t         excCause
);

    localparam int PhaseW = $clog2(`CPU_FETCH_CYCLES);
    localparam logic [PhaseW-1:0] LastFetch = PhaseW'(`CPU_FETCH_CYCLES - 1);

    cpuPkg::ctrlState_t state;
    cpuPkg::ctrlState_t nextState;
    cpuPkg::ctrlState_t decoded;
    cpuPkg::shiftOp_t shiftMode;
    logic [PhaseW-1:0] phase;
    logic [PhaseW-1:0] nextPhase;
    logic isTypeR;

    assign isTypeR = opcode == cpuPkg::OpTypeR;

    // Execute state for the instruction in IR
    always_comb begin
        decoded = cpuPkg::StException;
        if (opcode == cpuPkg::OpAddi) begin
            decoded = cpuPkg::StAluOp;
        end else if (isTypeR) begin
            case (funct)
                cpuPkg::FnAdd, cpuPkg::FnSub:
                    decoded = cpuPkg::StAluOp;
                cpuPkg::FnSll, cpuPkg::FnSrl, cpuPkg::FnSra, cpuPkg::FnSllv, cpuPkg::FnSrav:
                    decoded = cpuPkg::StShiftOp;
                cpuPkg::FnMult:
                    decoded = cpuPkg::StMultOp;
                cpuPkg::FnMfhi, cpuPkg::FnMflo:
                    decoded = cpuPkg::StMoveHiLo;
                default:
                    decoded = cpuPkg::StException;
            endcase
        end
    end

    always_comb begin
        case (funct)
            cpuPkg::FnSrl:
                shiftMode = cpuPkg::ShSrl;
            cpuPkg::FnSra, cpuPkg::FnSrav:
                shiftMode = cpuPkg::ShSra;
            default:
                shiftMode = cpuPkg::ShSll;
        endcase
    end

    always_comb begin
        nextState = state;
        nextPhase = phase + 1'b1;
        case (state)
            cpuPkg::StReset: begin
                if (phase != '0) begin
                    nextState = cpuPkg::StFetch;
                    nextPhase = '0;
                end
            end
            cpuPkg::StFetch: begin
                if (phase == LastFetch) begin
                    nextState = cpuPkg::StDecode;
                    nextPhase = '0;
                end
            end
            cpuPkg::StDecode: begin
                if (phase == PhaseW'(1)) begin
                    nextState = decoded;
                    nextPhase = '0;
                end
            end
            cpuPkg::StAluOp: begin
                if (phase == PhaseW'(1)) begin
                    nextState = cpuPkg::StFetch;
                    nextPhase = '0;
                end
            end
            cpuPkg::StShiftOp: begin
                if (phase == PhaseW'(2)) begin
                    nextState = cpuPkg::StFetch;
                    nextPhase = '0;
                end
            end
            cpuPkg::StMultOp: begin
                // Hold in the wait phase until the multiplier finishes
                if (phase == PhaseW'(1) && !multDone) begin
                    nextPhase = phase;
                end else if (phase == PhaseW'(2)) begin
                    nextState = cpuPkg::StFetch;
                    nextPhase = '0;
                end
            end
            default: begin
                nextState = cpuPkg::StFetch;
                nextPhase = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= cpuPkg::StReset;
            phase <= '0;
        end else begin
            state <= nextState;
            phase <= nextPhase;
        end
    end

    always_comb begin
        pcWrite = 1'b0;
        irWrite = 1'b0;
        instrRead = 1'b0;
        abLoad = 1'b0;
        aluOutLoad = 1'b0;
        multStart = 1'b0;
        hiLoLoad = 1'b0;
        regWrite = 1'b0;
        excValid = 1'b0;
        excCause = cpuPkg::ExcNone;
        shiftOp = cpuPkg::ShNone;
        wbSrc = cpuPkg::WbAluOut;
        // Operand and destination selects follow IR
        aluOp = (isTypeR && funct == cpuPkg::FnSub) ? cpuPkg::AluSub : cpuPkg::AluAdd;
        aluSrcB = !isTypeR;
        wrSelRt = !isTypeR;
        shiftVar = funct == cpuPkg::FnSllv || funct == cpuPkg::FnSrav;
        case (state)
            cpuPkg::StReset: begin
                // Stack pointer write once reset is released
                if (phase != '0) begin
                    regWrite = 1'b1;
                    wbSrc = cpuPkg::WbSpInit;
                end
            end
            cpuPkg::StFetch: begin
                instrRead = phase != LastFetch;
                pcWrite = phase == LastFetch;
                irWrite = phase == LastFetch;
            end
            cpuPkg::StDecode: begin
                abLoad = phase == PhaseW'(1);
            end
            cpuPkg::StAluOp: begin
                if (phase == '0) begin
                    aluOutLoad = 1'b1;
                end else if (overflow) begin
                    excValid = 1'b1;
                    excCause = cpuPkg::ExcOverflow;
                end else begin
                    regWrite = 1'b1;
                end
            end
            cpuPkg::StShiftOp: begin
                if (phase == '0) begin
                    shiftOp = cpuPkg::ShLoad;
                end else if (phase == PhaseW'(1)) begin
                    shiftOp = shiftMode;
                end else begin
                    regWrite = 1'b1;
                    wbSrc = cpuPkg::WbShift;
                end
            end
            cpuPkg::StMultOp: begin
                multStart = phase == '0;
                hiLoLoad = phase == PhaseW'(2);
            end
            cpuPkg::StMoveHiLo: begin
                regWrite = 1'b1;
                wbSrc = (funct == cpuPkg::FnMfhi) ? cpuPkg::WbHi : cpuPkg::WbLo;
            end
            default: begin
                excValid = 1'b1;
                excCause = cpuPkg::ExcBadOpcode;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (!rstN) !(regWrite && excValid))
        else $error("register write during an exception cycle");

    assert property (@(posedge clk) disable iff (!rstN)
        multStart |-> state == cpuPkg::StMultOp)
        else $error("multiplier started outside MultOp");

endmodule

//--- source/coreDatapath.sv
// Datapath of the multicycle core: PC, IR, operand and result registers, write-back mux
`include "cpu_cfg.svh"

module coreDatapath (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [`CPU_XLEN-1:0]      instr,
    input  logic                      pcWrite,
    input  logic                      irWrite,
    input  logic                      abLoad,
    input  logic                      aluOutLoad,
    input  cpuPkg::aluOp_t            aluOp,
    input  logic                      aluSrcB,
    input  cpuPkg::shiftOp_t          shiftOp,
    input  logic                      shiftVar,
    input  logic                      multStart,
    input  logic                      hiLoLoad,
    input  logic                      regWrite,
    input  cpuPkg::wbSrc_t            wbSrc,
    input  logic                      wrSelRt,
    output logic [`CPU_OPCODE_W-1:0]  opcode,
    output logic [`CPU_OPCODE_W-1:0]  funct,
    output logic                      overflow,
    output logic                      multDone,
    output logic [`CPU_XLEN-1:0]      instrAddr,
    output logic                      regWrEn,
    output logic [`CPU_REG_AW-1:0]    regWrAddr,
    output logic [`CPU_XLEN-1:0]      regWrData
);

    localparam int ShW = $clog2(`CPU_XLEN);

    logic [`CPU_XLEN-1:0] pc, ir, regA, regB, aluOut, hi, lo;
    logic [`CPU_XLEN-1:0] rdDataA, rdDataB, immExt, aluB, aluResult;
    logic [`CPU_XLEN-1:0] shiftOut, multHi, multLo;
    logic [ShW-1:0] shiftAmount;
    logic aluOverflow;
    logic multBusy;

    assign opcode = ir[`CPU_XLEN-1 -: `CPU_OPCODE_W];
    assign funct = ir[`CPU_OPCODE_W-1:0];
    assign immExt = {{(`CPU_XLEN - 16){ir[15]}}, ir[15:0]};
    assign aluB = aluSrcB ? immExt : regB;
    assign shiftAmount = shiftVar ? regA[ShW-1:0] : ir[10:6];
    assign instrAddr = pc;
    assign regWrEn = regWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            overflow <= 1'b0;
            hi <= '0;
            lo <= '0;
        end else begin
            if (pcWrite) begin
                pc <= pc + `CPU_XLEN'(4);
            end
            if (aluOutLoad) begin
                overflow <= aluOverflow;
            end
            if (hiLoLoad) begin
                hi <= multHi;
                lo <= multLo;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite) begin
            ir <= instr;
        end
        if (abLoad) begin
            regA <= rdDataA;
            regB <= rdDataB;
        end
        if (aluOutLoad) begin
            aluOut <= aluResult;
        end
    end

    // Stack pointer init overrides the rd/rt choice
    assign regWrAddr = (wbSrc == cpuPkg::WbSpInit) ? `CPU_REG_AW'(`CPU_SP_INDEX)
                     : (wrSelRt ? ir[20:16] : ir[15:11]);

    always_comb begin
        case (wbSrc)
            cpuPkg::WbShift:  regWrData = shiftOut;
            cpuPkg::WbHi:     regWrData = hi;
            cpuPkg::WbLo:     regWrData = lo;
            cpuPkg::WbSpInit: regWrData = `CPU_XLEN'(`CPU_SP_INIT);
            default:          regWrData = aluOut;
        endcase
    end

    regFile i_regFile (
        .clk(clk), .rstN(rstN),
        .rdAddrA(ir[25:21]), .rdAddrB(ir[20:16]),
        .wrEn(regWrite), .wrAddr(regWrAddr), .wrData(regWrData),
        .rdDataA(rdDataA), .rdDataB(rdDataB)
    );

    aluUnit i_aluUnit (
        .a(regA), .b(aluB), .op(aluOp), .result(aluResult), .overflow(aluOverflow)
    );

    shiftUnit i_shiftUnit (
        .clk(clk), .rstN(rstN), .op(shiftOp), .din(regB), .amount(shiftAmount),
        .dout(shiftOut)
    );

    multUnit i_multUnit (
        .clk(clk), .rstN(rstN), .start(multStart), .multiplicand(regA), .multiplier(regB),
        .busy(multBusy), .done(multDone), .hi(multHi), .lo(multLo)
    );

    // Hi/Lo capture only once the multiplier has settled
    assert property (@(posedge clk) disable iff (!rstN) hiLoLoad |-> !multBusy)
        else $error("Hi/Lo loaded while the multiplier is busy");

endmodule

//--- source/cpuCore.sv
// Top of the multicycle MIPS-subset core joining controller and datapath
`include "cpu_cfg.svh"

module cpuCore (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic [`CPU_XLEN-1:0]    instr,
    output logic [`CPU_XLEN-1:0]    instrAddr,
    output logic                    instrRead,
    output logic                    regWrEn,
    output logic [`CPU_REG_AW-1:0]  regWrAddr,
    output logic [`CPU_XLEN-1:0]    regWrData,
    output logic                    excValid,
    output cpuPkg::excCause_t       excCause
);

    logic [`CPU_OPCODE_W-1:0] opcode, funct;
    logic overflow, multDone;
    logic pcWrite, irWrite, abLoad, aluOutLoad, aluSrcB, shiftVar;
    logic multStart, hiLoLoad, regWrite, wrSelRt;
    cpuPkg::aluOp_t aluOp;
    cpuPkg::shiftOp_t shiftOp;
    cpuPkg::wbSrc_t wbSrc;

    controlFsm i_controlFsm (
        .clk(clk), .rstN(rstN), .opcode(opcode), .funct(funct),
        .overflow(overflow), .multDone(multDone),
        .pcWrite(pcWrite), .irWrite(irWrite), .instrRead(instrRead), .abLoad(abLoad),
        .aluOutLoad(aluOutLoad), .aluOp(aluOp), .aluSrcB(aluSrcB), .shiftOp(shiftOp),
        .shiftVar(shiftVar), .multStart(multStart), .hiLoLoad(hiLoLoad),
        .regWrite(regWrite), .wbSrc(wbSrc), .wrSelRt(wrSelRt),
        .excValid(excValid), .excCause(excCause)
    );

    coreDatapath i_coreDatapath (
        .clk(clk), .rstN(rstN), .instr(instr),
        .pcWrite(pcWrite), .irWrite(irWrite), .abLoad(abLoad), .aluOutLoad(aluOutLoad),
        .aluOp(aluOp), .aluSrcB(aluSrcB), .shiftOp(shiftOp), .shiftVar(shiftVar),
        .multStart(multStart), .hiLoLoad(hiLoLoad), .regWrite(regWrite),
        .wbSrc(wbSrc), .wrSelRt(wrSelRt),
        .opcode(opcode), .funct(funct), .overflow(overflow), .multDone(multDone),
        .instrAddr(instrAddr), .regWrEn(regWrEn), .regWrAddr(regWrAddr),
        .regWrData(regWrData)
    );

endmodule

//--- dv/cpuCoreTb.sv
// Testbench for the multicycle core with random program, instruction memory and ISA model
`include "cpu_cfg.svh"

module cpuCoreTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ProgLen = 200;
    localparam int BaseTimeout = 100;
    localparam int MultAllowance = 50;

    typedef struct {
        bit isExc;
        cpuPkg::excCause_t cause;
        logic [`CPU_REG_AW-1:0] idx;
        logic [`CPU_XLEN-1:0] val;
        int multsBefore;
        int fetches;
    } expEvent_t;

    logic clk;
    logic rstN;
    logic [`CPU_XLEN-1:0] instr;
    logic [`CPU_XLEN-1:0] instrAddr;
    logic instrRead;
    logic regWrEn;
    logic [`CPU_REG_AW-1:0] regWrAddr;
    logic [`CPU_XLEN-1:0] regWrData;
    logic excValid;
    cpuPkg::excCause_t excCause;

    logic [31:0] prog [ProgLen];
    logic [31:0] modelRegs [32];
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    expEvent_t expQ[$];
    int pendingMults = 0;
    int modelFetches = 0;
    int fetchCount = 0;
    int seed = 93573;
    int mismatchCount = 0;
    int failCount = 0;
    logic [31:0] expPc = '0;
    logic prevRead = 1'b0;

    cpuCore i_cpuCore (
        .clk(clk), .rstN(rstN), .instr(instr), .instrAddr(instrAddr), .instrRead(instrRead),
        .regWrEn(regWrEn), .regWrAddr(regWrAddr), .regWrData(regWrData),
        .excValid(excValid), .excCause(excCause)
    );

    always #5 clk = ~clk;

    // Instruction memory answers 1 ns after each rising edge
    always @(posedge clk) begin
        #1;
        if (instrAddr[31:2] < ProgLen) begin
            instr <= prog[instrAddr[31:2]];
        end else begin
            instr <= {cpuPkg::OpTypeR, 20'd0, cpuPkg::FnMult};
        end
    end

    // PC moves by one word per fetch
    always @(negedge clk) begin
        if (instrRead && !prevRead) begin
            if (instrAddr !== expPc) begin
                $display("mismatch at %0t: fetch address %h, expected %h",
                         $time, instrAddr, expPc);
                mismatchCount++;
            end
            expPc = expPc + 32'd4;
            fetchCount <= fetchCount + 1;
        end
        prevRead = instrRead;
    end

    function automatic int unsigned randBelow(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] randomInstr();
        int unsigned pick;
        logic [4:0] rs, rt, rd, shamt;
        logic [5:0] fn;
        logic [15:0] imm;
        pick = randBelow(100);
        rs = 5'(randBelow(32));
        rt = 5'(randBelow(32));
        rd = 5'(randBelow(32));
        shamt = 5'(randBelow(32));
        imm = 16'(randBelow(32)) - 16'd16;
        if (pick < 5) begin
            // Undefined opcode or a dropped function such as SLT
            if (randBelow(2) == 0) begin
                return {3'b111, 3'(randBelow(8)), rs, rt, imm};
            end
            return {cpuPkg::OpTypeR, rs, rt, rd, 5'd0, 6'b101010};
        end else if (pick < 20) begin
            return {cpuPkg::OpAddi, rs, rt, imm};
        end else if (pick < 30) begin
            imm = (randBelow(2) == 0) ? 16'h7ff0 + 16'(randBelow(16))
                                      : 16'h8000 + 16'(randBelow(16));
            return {cpuPkg::OpAddi, rs, rt, imm};
        end else if (pick < 42) begin
            return {cpuPkg::OpTypeR, rs, rt, rd, 5'd0, cpuPkg::FnAdd};
        end else if (pick < 52) begin
            return {cpuPkg::OpTypeR, rs, rt, rd, 5'd0, cpuPkg::FnSub};
        end else if (pick < 72) begin
            case (randBelow(5))
                0: fn = cpuPkg::FnSll;
                1: fn = cpuPkg::FnSrl;
                2: fn = cpuPkg::FnSra;
                3: fn = cpuPkg::FnSllv;
                default: fn = cpuPkg::FnSrav;
            endcase
            return {cpuPkg::OpTypeR, rs, rt, rd, shamt, fn};
        end else if (pick < 80) begin
            return {cpuPkg::OpTypeR, rs, rt, 10'd0, cpuPkg::FnMult};
        end else if (pick < 90) begin
            return {cpuPkg::OpTypeR, 10'd0, rd, 5'd0, cpuPkg::FnMfhi};
        end
        return {cpuPkg::OpTypeR, 10'd0, rd, 5'd0, cpuPkg::FnMflo};
    endfunction

    function automatic void expectWrite(logic [4:0] idx, logic [31:0] val);
        expEvent_t e;
        e.isExc = 1'b0;
        e.cause = cpuPkg::ExcNone;
        e.idx = idx;
        e.val = val;
        e.multsBefore = pendingMults;
        e.fetches = modelFetches;
        pendingMults = 0;
        expQ.push_back(e);
        if (idx != 5'd0) begin
            modelRegs[idx] = val;
        end
    endfunction

    function automatic void expectExc(cpuPkg::excCause_t cause);
        expEvent_t e;
        e.isExc = 1'b1;
        e.cause = cause;
        e.idx = '0;
        e.val = '0;
        e.multsBefore = pendingMults;
        e.fetches = modelFetches;
        pendingMults = 0;
        expQ.push_back(e);
    endfunction

    // ISA semantics of one instruction as expected port events
    function automatic void modelExecute(logic [31:0] word);
        logic [4:0] rs, rt, rd, shamt;
        logic [31:0] a, b, res;
        longint prod;
        modelFetches++;
        rs = word[25:21];
        rt = word[20:16];
        rd = word[15:11];
        shamt = word[10:6];
        a = modelRegs[rs];
        b = modelRegs[rt];
        if (word[31:26] == cpuPkg::OpAddi) begin
            b = {{16{word[15]}}, word[15:0]};
            res = a + b;
            if (a[31] == b[31] && res[31] != a[31]) expectExc(cpuPkg::ExcOverflow);
            else expectWrite(rt, res);
        end else if (word[31:26] != cpuPkg::OpTypeR) begin
            expectExc(cpuPkg::ExcBadOpcode);
        end else begin
            case (word[5:0])
                cpuPkg::FnAdd: begin
                    res = a + b;
                    if (a[31] == b[31] && res[31] != a[31]) expectExc(cpuPkg::ExcOverflow);
                    else expectWrite(rd, res);
                end
                cpuPkg::FnSub: begin
                    res = a - b;
                    if (a[31] != b[31] && res[31] != a[31]) expectExc(cpuPkg::ExcOverflow);
                    else expectWrite(rd, res);
                end
                cpuPkg::FnSll: expectWrite(rd, b << shamt);
                cpuPkg::FnSrl: expectWrite(rd, b >> shamt);
                cpuPkg::FnSra: expectWrite(rd, $signed(b) >>> shamt);
                cpuPkg::FnSllv: expectWrite(rd, b << a[4:0]);
                cpuPkg::FnSrav: expectWrite(rd, $signed(b) >>> a[4:0]);
                cpuPkg::FnMult: begin
                    prod = longint'($signed(a)) * longint'($signed(b));
                    modelHi = prod[63:32];
                    modelLo = prod[31:0];
                    pendingMults++;
                end
                cpuPkg::FnMfhi: expectWrite(rd, modelHi);
                cpuPkg::FnMflo: expectWrite(rd, modelLo);
                default: expectExc(cpuPkg::ExcBadOpcode);
            endcase
        end
    endfunction

    task automatic awaitEvent(input int limit, output bit seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            cycles++;
            seen = regWrEn || excValid;
        end
    endtask

    task automatic compareEvent(input expEvent_t head, input int n);
        if (fetchCount != head.fetches) begin
            $display("mismatch at %0t: event %0d after %0d fetches, expected %0d",
                     $time, n, fetchCount, head.fetches);
            mismatchCount++;
        end
        if (head.isExc) begin
            if (!excValid || regWrEn || excCause != head.cause) begin
                $display("mismatch at %0t: event %0d expected exception %s, got excValid=%b %s",
                         $time, n, head.cause.name(), excValid, excCause.name());
                mismatchCount++;
            end
        end else begin
            if (!regWrEn || excValid || regWrAddr !== head.idx || regWrData !== head.val) begin
                $display("mismatch at %0t: event %0d expected r%0d=%h, got regWrEn=%b r%0d=%h",
                         $time, n, head.idx, head.val, regWrEn, regWrAddr, regWrData);
                mismatchCount++;
            end
        end
    endtask

    initial begin
        expEvent_t head;
        bit seen;
        int limit;
        int n;
        clk = 1'b0;
        rstN = 1'b0;
        instr = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        modelHi = '0;
        modelLo = '0;
        expectWrite(`CPU_SP_INDEX, `CPU_SP_INIT);
        for (int i = 0; i < ProgLen; i++) begin
            prog[i] = randomInstr();
            modelExecute(prog[i]);
        end
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        n = 0;
        while (expQ.size() > 0) begin
            head = expQ.pop_front();
            limit = BaseTimeout + MultAllowance * head.multsBefore;
            awaitEvent(limit, seen);
            if (!seen) begin
                $display("no register write or exception within %0d cycles for event %0d",
                         limit, n);
                failCount++;
                break;
            end
            compareEvent(head, n);
            n++;
        end
        $display("checked %0d events: %0d mismatches, %0d other errors",
                 n, mismatchCount, failCount);
        if (mismatchCount + failCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
source/cpuPkg.sv
source/aluUnit.sv
source/shiftUnit.sv
source/multUnit.sv
source/regFile.sv
source/controlFsm.sv
source/coreDatapath.sv
source/cpuCore.sv
dv/cpuCoreTb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

obj_dir/VcpuCoreTb: compile.f $(wildcard source/*.sv dv/*.sv include/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module cpuCoreTb -Mdir obj_dir -o VcpuCoreTb

test: obj_dir/VcpuCoreTb
	./obj_dir/VcpuCoreTb > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
